// ==== hw/host_pkg.sv ====
// shared widths, offsets and the address layout; NUM_CORES lives in the modules, max 64
package host_pkg;

  localparam int ADDR_WIDTH      = 16;
  localparam int DATA_WIDTH      = 64;
  localparam int REG_IDX_WIDTH   = 8;
  localparam int CORE_IDX_WIDTH  = 7;
  localparam int TRACE_BITS      = 8;
  localparam int EXIT_CODE_WIDTH = 8;

  // one-bit opcode on both channels
  localparam logic OP_READ  = 1'b0;
  localparam logic OP_WRITE = 1'b1;

  // core view offsets
  localparam logic [REG_IDX_WIDTH-1:0] REG_CORE_FINISH = REG_IDX_WIDTH'(0);

  // global view offsets
  localparam logic [REG_IDX_WIDTH-1:0] REG_TRACE_EN      = REG_IDX_WIDTH'(0);
  localparam logic [REG_IDX_WIDTH-1:0] REG_FINISHED_MASK = REG_IDX_WIDTH'(1);

  // read source, decode stage to response stage
  localparam logic [1:0] SRC_TRACE    = 2'd0;
  localparam logic [1:0] SRC_MASK     = 2'd1;
  localparam logic [1:0] SRC_CORE     = 2'd2;
  localparam logic [1:0] SRC_UNMAPPED = 2'd3;

  // top bit picks the view, 1 = core, 0 = global
  typedef union packed {
    struct packed {
      logic                      sel;
      logic [CORE_IDX_WIDTH-1:0] core_idx;
      logic [REG_IDX_WIDTH-1:0]  offset;
    } core_view;
    struct packed {
      logic                                  sel;
      logic [ADDR_WIDTH-REG_IDX_WIDTH-2:0]   rsvd;
      logic [REG_IDX_WIDTH-1:0]              offset;
    } glob_view;
  } host_addr_u;

endpackage

// ==== hw/host_fwd_decode.sv ====
// holds one request at a time; writes land on the edge the request moves into the merge
`timescale 1ns/1ps

module host_fwd_decode #(
  parameter int NUM_CORES = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,

  input  logic                                   fwd_v_i,
  input  logic                                   fwd_opcode_i,
  input  logic [host_pkg::ADDR_WIDTH-1:0]        fwd_addr_i,
  input  logic [host_pkg::DATA_WIDTH-1:0]        fwd_data_i,
  output logic                                   fwd_ready_and_o,

  input  logic                                   adv_i,
  output logic                                   dec_v_o,
  output logic                                   dec_opcode_o,
  output logic [host_pkg::ADDR_WIDTH-1:0]        dec_addr_o,
  output logic [1:0]                             rd_src_o,
  output logic [host_pkg::CORE_IDX_WIDTH-1:0]    rd_core_o,

  output logic [NUM_CORES-1:0]                   slice_wr_o,
  output logic [host_pkg::EXIT_CODE_WIDTH-1:0]   wr_code_o,
  output logic [host_pkg::TRACE_BITS-1:0]        trace_en_o
);

  // only the low bits of a write ever matter
  localparam int WD_WIDTH = (host_pkg::TRACE_BITS > host_pkg::EXIT_CODE_WIDTH) ?
                            host_pkg::TRACE_BITS : host_pkg::EXIT_CODE_WIDTH;

  localparam logic [host_pkg::CORE_IDX_WIDTH:0] NUM_CORES_L =
    (host_pkg::CORE_IDX_WIDTH+1)'(NUM_CORES);

  logic                                dec_v_r;
  logic                                dec_opcode_r;
  host_pkg::host_addr_u                dec_addr_r;
  logic [WD_WIDTH-1:0]                 dec_wdata_r;
  logic [host_pkg::TRACE_BITS-1:0]     trace_r;

  logic                                fwd_fire;
  logic                                wr_fire;
  logic                                core_in_range;
  logic [1:0]                          rd_src;

  assign fwd_ready_and_o = ~dec_v_r | adv_i;
  assign fwd_fire        = fwd_v_i & fwd_ready_and_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dec_v_r <= 1'b0;
    end
    else if (fwd_ready_and_o)
    begin
      dec_v_r <= fwd_v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fwd_fire)
    begin
      dec_opcode_r <= fwd_opcode_i;
      dec_addr_r   <= fwd_addr_i;
      dec_wdata_r  <= fwd_data_i[WD_WIDTH-1:0];
    end
  end

  assign core_in_range = ({1'b0, dec_addr_r.core_view.core_idx} < NUM_CORES_L);

  // address decode through the union
  always_comb
  begin
    rd_src = host_pkg::SRC_UNMAPPED;
    if (dec_addr_r.core_view.sel)
    begin
      if (core_in_range && (dec_addr_r.core_view.offset == host_pkg::REG_CORE_FINISH))
      begin
        rd_src = host_pkg::SRC_CORE;
      end
    end
    else
    begin
      case (dec_addr_r.glob_view.offset)
        host_pkg::REG_TRACE_EN:      rd_src = host_pkg::SRC_TRACE;
        host_pkg::REG_FINISHED_MASK: rd_src = host_pkg::SRC_MASK;
        default:                     rd_src = host_pkg::SRC_UNMAPPED;
      endcase
    end
  end

  assign wr_fire = dec_v_r & adv_i & (dec_opcode_r == host_pkg::OP_WRITE);

  // trace word, the only writable global
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      trace_r <= '0;
    end
    else if (wr_fire && (rd_src == host_pkg::SRC_TRACE))
    begin
      trace_r <= dec_wdata_r[host_pkg::TRACE_BITS-1:0];
    end
  end

  // one-hot strobe to the addressed slice
  always_comb
  begin
    slice_wr_o = '0;
    for (int i = 0; i < NUM_CORES; i++)
    begin
      slice_wr_o[i] = wr_fire && (rd_src == host_pkg::SRC_CORE) &&
                      (dec_addr_r.core_view.core_idx == host_pkg::CORE_IDX_WIDTH'(i));
    end
  end

  assign wr_code_o    = dec_wdata_r[host_pkg::EXIT_CODE_WIDTH-1:0];
  assign trace_en_o   = trace_r;
  assign dec_v_o      = dec_v_r;
  assign dec_opcode_o = dec_opcode_r;
  assign dec_addr_o   = dec_addr_r;
  assign rd_src_o     = rd_src;
  assign rd_core_o    = dec_addr_r.core_view.core_idx;

endmodule

// ==== hw/host_core_slice.sv ====
// first finish write wins; the flag and code stay until reset
`timescale 1ns/1ps

module host_core_slice (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  input  logic                                  wr_i,
  input  logic [host_pkg::EXIT_CODE_WIDTH-1:0]  code_i,

  output logic                                  finish_o,
  output logic [host_pkg::EXIT_CODE_WIDTH-1:0]  exit_code_o
);

  logic                                  finish_r;
  logic [host_pkg::EXIT_CODE_WIDTH-1:0]  code_r;

  // exit code reads as zero until the first finish
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      finish_r <= 1'b0;
      code_r   <= '0;
    end
    else if (wr_i && !finish_r)
    begin
      finish_r <= 1'b1;
      code_r   <= code_i;
    end
  end

  assign finish_o    = finish_r;
  assign exit_code_o = code_r;

endmodule

// ==== hw/host_rev_merge.sv ====
// single response register; fields hold until the response is taken
`timescale 1ns/1ps

module host_rev_merge #(
  parameter int NUM_CORES = 4
) (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,

  input  logic                                              dec_v_i,
  input  logic                                              dec_opcode_i,
  input  logic [host_pkg::ADDR_WIDTH-1:0]                   dec_addr_i,
  input  logic [1:0]                                        rd_src_i,
  input  logic [host_pkg::CORE_IDX_WIDTH-1:0]               rd_core_i,
  input  logic [host_pkg::TRACE_BITS-1:0]                   trace_en_i,
  input  logic [NUM_CORES-1:0]                              finish_i,
  input  logic [NUM_CORES*host_pkg::EXIT_CODE_WIDTH-1:0]    exit_code_i,
  output logic                                              adv_o,

  output logic                                              rev_v_o,
  input  logic                                              rev_ready_and_i,
  output logic                                              rev_opcode_o,
  output logic [host_pkg::ADDR_WIDTH-1:0]                   rev_addr_o,
  output logic [host_pkg::DATA_WIDTH-1:0]                   rev_data_o,

  output logic                                              all_finished_o
);

  logic                                  rev_v_r;
  logic                                  rev_opcode_r;
  logic [host_pkg::ADDR_WIDTH-1:0]       rev_addr_r;
  logic [host_pkg::DATA_WIDTH-1:0]       rev_data_r;

  logic                                  core_finish;
  logic [host_pkg::EXIT_CODE_WIDTH-1:0]  core_code;
  logic [host_pkg::DATA_WIDTH-1:0]       rd_data;

  // empty or draining this cycle
  assign adv_o = ~rev_v_r | rev_ready_and_i;

  // pick the addressed core
  always_comb
  begin
    core_finish = 1'b0;
    core_code   = '0;
    for (int i = 0; i < NUM_CORES; i++)
    begin
      if (rd_core_i == host_pkg::CORE_IDX_WIDTH'(i))
      begin
        core_finish = finish_i[i];
        core_code   = exit_code_i[i*host_pkg::EXIT_CODE_WIDTH +: host_pkg::EXIT_CODE_WIDTH];
      end
    end
  end

  // writes answer with zero
  always_comb
  begin
    rd_data = '0;
    if (dec_opcode_i == host_pkg::OP_READ)
    begin
      case (rd_src_i)
        host_pkg::SRC_CORE:  rd_data = host_pkg::DATA_WIDTH'({core_finish, core_code});
        host_pkg::SRC_MASK:  rd_data = host_pkg::DATA_WIDTH'(finish_i);
        host_pkg::SRC_TRACE: rd_data = host_pkg::DATA_WIDTH'(trace_en_i);
        default:             rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rev_v_r <= 1'b0;
    end
    else if (adv_o)
    begin
      rev_v_r <= dec_v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (adv_o && dec_v_i)
    begin
      rev_opcode_r <= dec_opcode_i;
      rev_addr_r   <= dec_addr_i;
      rev_data_r   <= rd_data;
    end
  end

  assign rev_v_o        = rev_v_r;
  assign rev_opcode_o   = rev_opcode_r;
  assign rev_addr_o     = rev_addr_r;
  assign rev_data_o     = rev_data_r;
  assign all_finished_o = &finish_i;

endmodule

// ==== hw/host_dev_top.sv ====
// request to response is two cycles with no back-pressure; NUM_CORES from 1 to 64
`timescale 1ns/1ps

module host_dev_top #(
  parameter int NUM_CORES = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  input  logic                                fwd_v_i,
  input  logic                                fwd_opcode_i,
  input  logic [host_pkg::ADDR_WIDTH-1:0]     fwd_addr_i,
  input  logic [host_pkg::DATA_WIDTH-1:0]     fwd_data_i,
  output logic                                fwd_ready_and_o,

  output logic                                rev_v_o,
  input  logic                                rev_ready_and_i,
  output logic                                rev_opcode_o,
  output logic [host_pkg::ADDR_WIDTH-1:0]     rev_addr_o,
  output logic [host_pkg::DATA_WIDTH-1:0]     rev_data_o,

  output logic [NUM_CORES-1:0]                finish_o,
  output logic                                all_finished_o,
  output logic [host_pkg::TRACE_BITS-1:0]     trace_en_o
);

  logic                                             adv;
  logic                                             dec_v;
  logic                                             dec_opcode;
  logic [host_pkg::ADDR_WIDTH-1:0]                  dec_addr;
  logic [1:0]                                       rd_src;
  logic [host_pkg::CORE_IDX_WIDTH-1:0]              rd_core;
  logic [NUM_CORES-1:0]                             slice_wr;
  logic [host_pkg::EXIT_CODE_WIDTH-1:0]             wr_code;
  logic [NUM_CORES*host_pkg::EXIT_CODE_WIDTH-1:0]   exit_code;

  host_fwd_decode #(
    .NUM_CORES (NUM_CORES)
  ) u_dec (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fwd_v_i         (fwd_v_i),
    .fwd_opcode_i    (fwd_opcode_i),
    .fwd_addr_i      (fwd_addr_i),
    .fwd_data_i      (fwd_data_i),
    .fwd_ready_and_o (fwd_ready_and_o),
    .adv_i           (adv),
    .dec_v_o         (dec_v),
    .dec_opcode_o    (dec_opcode),
    .dec_addr_o      (dec_addr),
    .rd_src_o        (rd_src),
    .rd_core_o       (rd_core),
    .slice_wr_o      (slice_wr),
    .wr_code_o       (wr_code),
    .trace_en_o      (trace_en_o)
  );

  // one slice per core, all on the shared code bus
  for (genvar i = 0; i < NUM_CORES; i++)
  begin : g_core
    host_core_slice u_slice (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .wr_i        (slice_wr[i]),
      .code_i      (wr_code),
      .finish_o    (finish_o[i]),
      .exit_code_o (exit_code[i*host_pkg::EXIT_CODE_WIDTH +: host_pkg::EXIT_CODE_WIDTH])
    );
  end

  host_rev_merge #(
    .NUM_CORES (NUM_CORES)
  ) u_merge (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .dec_v_i         (dec_v),
    .dec_opcode_i    (dec_opcode),
    .dec_addr_i      (dec_addr),
    .rd_src_i        (rd_src),
    .rd_core_i       (rd_core),
    .trace_en_i      (trace_en_o),
    .finish_i        (finish_o),
    .exit_code_i     (exit_code),
    .adv_o           (adv),
    .rev_v_o         (rev_v_o),
    .rev_ready_and_i (rev_ready_and_i),
    .rev_opcode_o    (rev_opcode_o),
    .rev_addr_o      (rev_addr_o),
    .rev_data_o      (rev_data_o),
    .all_finished_o  (all_finished_o)
  );

endmodule

// ==== sim/host_dev_chk.sv ====
// bound into every host_dev_top; checks are off while rst_n_i is low except the reset exit
`timescale 1ns/1ps

module host_dev_chk #(
  parameter int NUM_CORES = 4
) (
  input logic                            clk_i,
  input logic                            rst_n_i,
  input logic                            fwd_ready_and_i,
  input logic                            rev_v_i,
  input logic                            rev_ready_and_i,
  input logic                            rev_opcode_i,
  input logic [host_pkg::ADDR_WIDTH-1:0] rev_addr_i,
  input logic [host_pkg::DATA_WIDTH-1:0] rev_data_i,
  input logic [NUM_CORES-1:0]            finish_i,
  input logic                            all_finished_i
);

  int unsigned fail_cnt = 0;

  // a stalled response keeps valid and every field
  a_rev_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rev_v_i && !rev_ready_and_i |=> rev_v_i && $stable(rev_opcode_i) &&
                                    $stable(rev_addr_i) && $stable(rev_data_i))
  else
  begin
    $error("response dropped or changed while the consumer stalled");
    fail_cnt = fail_cnt + 1;
  end

  // finish flags only ever rise
  a_finish_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (($past(finish_i) & ~finish_i) == '0))
  else
  begin
    $error("a finish flag fell outside reset");
    fail_cnt = fail_cnt + 1;
  end

  a_all_finished: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    all_finished_i == (&finish_i))
  else
  begin
    $error("all_finished_o does not match the AND of finish_o");
    fail_cnt = fail_cnt + 1;
  end

  // no response and ready to accept on the first edge out of reset
  a_reset_exit: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !rev_v_i && fwd_ready_and_i)
  else
  begin
    $error("response valid or request not ready right after reset");
    fail_cnt = fail_cnt + 1;
  end

endmodule

bind host_dev_top host_dev_chk #(
  .NUM_CORES (NUM_CORES)
) u_chk (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .fwd_ready_and_i (fwd_ready_and_o),
  .rev_v_i         (rev_v_o),
  .rev_ready_and_i (rev_ready_and_i),
  .rev_opcode_i    (rev_opcode_o),
  .rev_addr_i      (rev_addr_o),
  .rev_data_i      (rev_data_o),
  .finish_i        (finish_o),
  .all_finished_i  (all_finished_o)
);

// ==== sim/tb_host_dev.sv ====
// drives host_dev_top with NUM_CORES = 4; expected responses come from a register model
`timescale 1ns/1ps

module tb_host_dev;

  localparam int NUM_CORES    = 4;
  localparam int AW           = host_pkg::ADDR_WIDTH;
  localparam int DW           = host_pkg::DATA_WIDTH;
  localparam int CLK_NS       = 20;
  localparam int N_RANDOM     = 120;
  // directed plus random requests, worst case cycles each, with margin
  localparam int TXN_MAX      = 300;
  localparam int WORST_CYCLES = 8;
  localparam int WD_NS        = TXN_MAX * WORST_CYCLES * CLK_NS * 4;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     fwd_v_i;
  logic                     fwd_opcode_i;
  logic [AW-1:0]            fwd_addr_i;
  logic [DW-1:0]            fwd_data_i;
  logic                     fwd_ready_and_o;
  logic                     rev_v_o;
  logic                     rev_ready_and_i;
  logic                     rev_opcode_o;
  logic [AW-1:0]            rev_addr_o;
  logic [DW-1:0]            rev_data_o;
  logic [NUM_CORES-1:0]     finish_o;
  logic                     all_finished_o;
  logic [host_pkg::TRACE_BITS-1:0] trace_en_o;

  // register model
  logic [host_pkg::TRACE_BITS-1:0]      m_trace;
  logic [NUM_CORES-1:0]                 m_finish;
  logic [host_pkg::EXIT_CODE_WIDTH-1:0] m_code [NUM_CORES];
  // {opcode, addr, data} per outstanding request
  logic [DW+AW:0]           exp_q [$];

  integer seed = 32'hc4e290bd;
  logic   rand_rdy;
  int     errors;
  int     acc_cnt;
  int     resp_cnt;

  host_dev_top #(
    .NUM_CORES (NUM_CORES)
  ) dut0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fwd_v_i         (fwd_v_i),
    .fwd_opcode_i    (fwd_opcode_i),
    .fwd_addr_i      (fwd_addr_i),
    .fwd_data_i      (fwd_data_i),
    .fwd_ready_and_o (fwd_ready_and_o),
    .rev_v_o         (rev_v_o),
    .rev_ready_and_i (rev_ready_and_i),
    .rev_opcode_o    (rev_opcode_o),
    .rev_addr_o      (rev_addr_o),
    .rev_data_o      (rev_data_o),
    .finish_o        (finish_o),
    .all_finished_o  (all_finished_o),
    .trace_en_o      (trace_en_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  function automatic logic [AW-1:0] core_addr(input int idx, input int off);
    core_addr = {1'b1, 7'(idx), 8'(off)};
  endfunction

  function automatic logic [AW-1:0] glob_addr(input int off);
    glob_addr = {1'b0, 7'd0, 8'(off)};
  endfunction

  task automatic check_value(input string name, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // applies one accepted request to the model in arrival order
  task automatic model_accept(input logic op, input logic [AW-1:0] addr,
                              input logic [DW-1:0] data);
    logic [6:0]    idx;
    logic [7:0]    off;
    logic [DW-1:0] rdata;
    idx   = addr[14:8];
    off   = addr[7:0];
    rdata = '0;
    if (addr[15])
    begin
      if (int'(idx) < NUM_CORES && off == 8'd0)
      begin
        if (op == host_pkg::OP_WRITE && !m_finish[idx])
        begin
          m_finish[idx] = 1'b1;
          m_code[idx]   = data[7:0];
        end
        else if (op == host_pkg::OP_READ)
          rdata = {55'd0, m_finish[idx], m_code[idx]};
      end
    end
    else if (off == 8'd0)
    begin
      if (op == host_pkg::OP_WRITE)
        m_trace = data[host_pkg::TRACE_BITS-1:0];
      else
        rdata = DW'(m_trace);
    end
    else if (off == 8'd1 && op == host_pkg::OP_READ)
      rdata = DW'(m_finish);
    exp_q.push_back({op, addr, rdata});
  endtask

  task automatic check_response();
    logic [DW+AW:0] e;
    if (exp_q.size() == 0)
    begin
      $display("response seen with no request outstanding at %0t", $time);
      errors++;
    end
    else
    begin
      e = exp_q.pop_front();
      check_value("rev_opcode_o", DW'(rev_opcode_o), DW'(e[DW+AW]));
      check_value("rev_addr_o", DW'(rev_addr_o), DW'(e[DW+AW-1:DW]));
      check_value("rev_data_o", rev_data_o, e[DW-1:0]);
    end
  endtask

  // both transfers use the values settled before this edge
  always @(posedge clk_i)
  begin
    if (rst_n_i)
    begin
      if (rev_v_o && rev_ready_and_i)
      begin
        check_response();
        resp_cnt++;
      end
      if (fwd_v_i && fwd_ready_and_o)
      begin
        model_accept(fwd_opcode_i, fwd_addr_i, fwd_data_i);
        acc_cnt++;
      end
    end
  end

  // next falling edge, with a new draw for the response ready
  task automatic tick();
    @(negedge clk_i);
    if (rand_rdy)
      rev_ready_and_i = (($random(seed) & 3) != 0);
    else
      rev_ready_and_i = 1'b1;
  endtask

  task automatic send_req(input logic op, input logic [AW-1:0] addr,
                          input logic [DW-1:0] data);
    int start;
    start        = acc_cnt;
    fwd_v_i      = 1'b1;
    fwd_opcode_i = op;
    fwd_addr_i   = addr;
    fwd_data_i   = data;
    tick();
    while (acc_cnt == start)
      tick();
    fwd_v_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0)
      tick();
  endtask

  task automatic check_status();
    check_value("trace_en_o", DW'(trace_en_o), DW'(m_trace));
    check_value("finish_o", DW'(finish_o), DW'(m_finish));
    check_value("all_finished_o", DW'(all_finished_o), DW'(&m_finish));
  endtask

  initial
  begin
    #(WD_NS);
    $display("watchdog expired after %0d ns with %0d requests and %0d responses",
             WD_NS, acc_cnt, resp_cnt);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    int            pick;
    logic          op;
    logic [AW-1:0] addr;
    logic [DW-1:0] wdata;
    rst_n_i         = 1'b0;
    fwd_v_i         = 1'b0;
    fwd_opcode_i    = 1'b0;
    fwd_addr_i      = '0;
    fwd_data_i      = '0;
    rev_ready_and_i = 1'b1;
    rand_rdy        = 1'b0;
    errors          = 0;
    acc_cnt         = 0;
    resp_cnt        = 0;
    m_trace         = '0;
    m_finish        = '0;
    for (int i = 0; i < NUM_CORES; i++)
      m_code[i] = '0;
    repeat (2) @(posedge clk_i);
    tick();
    rst_n_i = 1'b1;

    // state right after reset
    tick();
    check_status();
    check_value("rev_v_o", DW'(rev_v_o), '0);
    check_value("fwd_ready_and_o", DW'(fwd_ready_and_o), DW'(1));

    // trace word write and read back
    send_req(host_pkg::OP_WRITE, glob_addr(0), 64'h1234_5678_9abc_de5a);
    send_req(host_pkg::OP_READ, glob_addr(0), '0);
    drain();
    check_status();

    // core finish, read back, second write ignored
    send_req(host_pkg::OP_WRITE, core_addr(1, 0), 64'h0000_0000_0000_aa33);
    send_req(host_pkg::OP_READ, core_addr(1, 0), '0);
    send_req(host_pkg::OP_WRITE, core_addr(1, 0), 64'h77);
    send_req(host_pkg::OP_READ, core_addr(1, 0), '0);
    drain();
    check_status();

    // unmapped reads and writes, finished mask is read-only
    send_req(host_pkg::OP_READ, core_addr(NUM_CORES, 0), '0);
    send_req(host_pkg::OP_READ, core_addr(127, 0), '0);
    send_req(host_pkg::OP_READ, core_addr(0, 1), '0);
    send_req(host_pkg::OP_READ, glob_addr(2), '0);
    send_req(host_pkg::OP_READ, glob_addr(255), '0);
    send_req(host_pkg::OP_WRITE, core_addr(NUM_CORES, 0), 64'h55);
    send_req(host_pkg::OP_WRITE, core_addr(2, 1), 64'h66);
    send_req(host_pkg::OP_WRITE, glob_addr(1), '1);
    send_req(host_pkg::OP_WRITE, glob_addr(5), 64'h99);
    drain();
    check_status();

    // remaining cores one by one; all_finished_o only on the last
    for (int i = 0; i < NUM_CORES; i++)
    begin
      if (i != 1)
      begin
        send_req(host_pkg::OP_WRITE, core_addr(i, 0), DW'(8'h10 + i));
        send_req(host_pkg::OP_READ, glob_addr(1), '0);
        drain();
        check_status();
      end
    end

    // random back-pressure and gaps, trace write then read back to back
    rand_rdy = 1'b1;
    for (int i = 0; i < N_RANDOM; i++)
    begin
      pick = $random(seed) & 7;
      case (pick)
        0, 5:    addr = glob_addr(0);
        1:       addr = glob_addr(1);
        2, 3:    addr = core_addr($random(seed) & 7, 0);
        4:       addr = core_addr($random(seed) & 3, 1 + ($random(seed) & 15));
        default: addr = glob_addr(2 + ($random(seed) & 127));
      endcase
      op    = (($random(seed) & 1) != 0);
      wdata = {$random(seed), $random(seed)};
      if (($random(seed) & 3) == 0)
        tick();
      send_req(op, addr, wdata);
      if (i % 4 == 0)
      begin
        send_req(host_pkg::OP_WRITE, glob_addr(0), ~wdata);
        send_req(host_pkg::OP_READ, glob_addr(0), '0);
      end
    end
    drain();
    check_status();

    $display("closing counts: %0d value errors, %0d checker errors, %0d requests, %0d responses",
             errors, dut0.u_chk.fail_cnt, acc_cnt, resp_cnt);
    if (errors == 0 && dut0.u_chk.fail_cnt == 0 && acc_cnt == resp_cnt)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== src.f ====
hw/host_pkg.sv
hw/host_fwd_decode.sv
hw/host_core_slice.sv
hw/host_rev_merge.sv
hw/host_dev_top.sv
sim/host_dev_chk.sv
sim/tb_host_dev.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the host device testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=tb_host_dev

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module "$TOP" -Mdir "$BUILD_DIR" -f src.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# keep running after a checker error so the testbench prints its verdict
output=$("./$BUILD_DIR/V$TOP" +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
